/* src/riscv_pkg.sv */
package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int NUM_REGS = 32;

  // Major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 as seen by OP_IMM and OP_REG
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,  // ADD, SUB, ADDI
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,  // SRL and SRA, split by funct7
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // Branches and JALR share the same 3-bit space
  localparam funct3_e F3_BEQ  = F3_ADD;
  localparam funct3_e F3_BNE  = F3_SLL;
  localparam funct3_e F3_BLT  = F3_XOR;
  localparam funct3_e F3_BGE  = F3_SR;
  localparam funct3_e F3_BLTU = F3_OR;
  localparam funct3_e F3_BGEU = F3_AND;
  localparam funct3_e F3_JALR = F3_ADD;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

  localparam word_t INSN_ECALL = 32'h0000_0073;

endpackage

/* src/core_pkg.sv */
package core_pkg;

  import riscv_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP,     // JAL
    BR_JUMP_REG  // JALR
  } br_cond_e;

  // Decoded control word
  typedef struct packed {
    alu_op_e  alu_op;
    logic     src_a_pc;   // Operand A is the PC
    logic     src_b_imm;  // Operand B is the immediate
    br_cond_e br_cond;
    logic     reg_write;
    logic     wb_link;    // Write PC+4
    logic     halt_req;
    reg_idx_t rd;
    word_t    imm;
  } ctrl_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
    word_t    pc;
  } commit_t;

  localparam ctrl_t CTRL_NOP = '{
    alu_op:    ALU_ADD,
    src_a_pc:  1'b0,
    src_b_imm: 1'b0,
    br_cond:   BR_NONE,
    reg_write: 1'b0,
    wb_link:   1'b0,
    halt_req:  1'b0,
    rd:        '0,
    imm:       '0
  };

endpackage

/* src/insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder
  import riscv_pkg::*;
  import core_pkg::*;
(
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output ctrl_t    ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       reg_ok;    // funct7 legal for OP_REG
  logic       imm_ok;    // funct7 legal for shift immediates
  alu_op_e    arith_op;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign reg_ok = (funct7 == F7_BASE) ||
                  (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
  assign imm_ok = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
                  (funct3 == F3_SR)  ? (funct7 == F7_BASE || funct7 == F7_ALT) : 1'b1;

  // Shared by OP_IMM and OP_REG; bit 30 picks SUB and SRA
  always_comb begin
    case (funct3)
      F3_ADD:  arith_op = (opcode == OP_REG && insn[30]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = insn[30] ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl    = CTRL_NOP;  // Anything unmatched stays a no-op
    ctrl.rd = insn[11:7];
    case (opcode)
      OP_LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.src_b_imm = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_JAL: begin
        ctrl.br_cond   = BR_JUMP;
        ctrl.imm       = imm_j;
        ctrl.reg_write = 1'b1;
        ctrl.wb_link   = 1'b1;
      end
      OP_JALR: if (funct3 == F3_JALR) begin
        ctrl.br_cond   = BR_JUMP_REG;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.wb_link   = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.imm = imm_b;
        case (funct3)
          F3_BEQ:  ctrl.br_cond = BR_EQ;
          F3_BNE:  ctrl.br_cond = BR_NE;
          F3_BLT:  ctrl.br_cond = BR_LT;
          F3_BGE:  ctrl.br_cond = BR_GE;
          F3_BLTU: ctrl.br_cond = BR_LTU;
          F3_BGEU: ctrl.br_cond = BR_GEU;
          default: ctrl.br_cond = BR_NONE;  // 010 and 011 are reserved
        endcase
      end
      OP_IMM: if (imm_ok) begin
        ctrl.alu_op    = arith_op;
        ctrl.src_b_imm = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
      end
      OP_REG: if (reg_ok) begin
        ctrl.alu_op    = arith_op;
        ctrl.reg_write = 1'b1;
      end
      OP_SYSTEM: ctrl.halt_req = (insn == INSN_ECALL);
      default: ;
    endcase
  end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import riscv_pkg::*;
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  commit_t  wr
);

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
  import riscv_pkg::*;
  import core_pkg::*;
(
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  assign op_a  = ctrl.src_a_pc ? pc : rs1_data;    // AUIPC uses the PC
  assign op_b  = ctrl.src_b_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'b0, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;  // Sign fill
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = op_a + op_b;
    endcase
  end

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import riscv_pkg::*;
  import core_pkg::*;
(
  input  ctrl_t     ctrl,
  input  word_t     pc,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output redirect_t redirect
);

  logic  eq;
  logic  lt;
  logic  ltu;
  logic  is_jalr;
  word_t sum;

  assign eq      = (rs1_data == rs2_data);
  assign lt      = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu     = (rs1_data < rs2_data);
  assign is_jalr = (ctrl.br_cond == BR_JUMP_REG);

  // JALR is register relative, everything else PC relative
  assign sum = (is_jalr ? rs1_data : pc) + ctrl.imm;

  always_comb begin
    redirect.target = is_jalr ? {sum[31:1], 1'b0} : sum;
    case (ctrl.br_cond)
      BR_EQ:                redirect.taken = eq;
      BR_NE:                redirect.taken = !eq;
      BR_LT:                redirect.taken = lt;
      BR_GE:                redirect.taken = !lt;
      BR_LTU:               redirect.taken = ltu;
      BR_GEU:               redirect.taken = !ltu;
      BR_JUMP, BR_JUMP_REG: redirect.taken = 1'b1;
      default:              redirect.taken = 1'b0;
    endcase
  end

endmodule

/* src/commit_stage.sv */
`timescale 1ns/1ps

module commit_stage
  import riscv_pkg::*;
  import core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clk,
  input  logic      rst,
  input  ctrl_t     ctrl,
  input  word_t     alu_result,
  input  redirect_t redirect,
  output word_t     pc,
  output commit_t   commit,
  output logic      halt
);

  word_t pc_q;
  word_t pc_plus4;
  word_t pc_next;
  logic  halted_q;

  assign pc_plus4 = pc_q + 32'd4;
  assign pc_next  = redirect.taken ? redirect.target : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else if (!halted_q) begin
      if (ctrl.halt_req) begin
        halted_q <= 1'b1;  // PC stays on the ECALL
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  // Result of the instruction now at pc_q
  always_comb begin
    commit.we   = ctrl.reg_write && (ctrl.rd != '0) && !halted_q && !rst;
    commit.rd   = ctrl.rd;
    commit.data = ctrl.wb_link ? pc_plus4 : alu_result;  // Link address for JAL/JALR
    commit.pc   = pc_q;
  end

  assign pc   = pc_q;
  assign halt = halted_q;

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import riscv_pkg::*;
  import core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic    clk,
  input  logic    rst,
  output word_t   pc_to_imem,
  input  word_t   insn_from_imem,
  output commit_t commit,
  output logic    halt
);

  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  ctrl_t     ctrl;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_result;
  redirect_t redirect;

  insn_decoder insn_decoder_inst (
    .insn (insn_from_imem),
    .rs1  (rs1_idx),
    .rs2  (rs2_idx),
    .ctrl (ctrl)
  );

  // Write port fed back from the commit output
  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (commit)
  );

  alu alu_inst (
    .ctrl     (ctrl),
    .pc       (pc_to_imem),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  branch_unit branch_unit_inst (
    .ctrl     (ctrl),
    .pc       (pc_to_imem),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .redirect (redirect)
  );

  commit_stage #(
    .RESET_PC (RESET_PC)
  ) commit_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .redirect   (redirect),
    .pc         (pc_to_imem),
    .commit     (commit),
    .halt       (halt)
  );

endmodule

/* test/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts
  import riscv_pkg::*;
  import core_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input word_t   pc,
  input commit_t commit,
  input logic    halt
);

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  // Only reset clears the halted flag
  halt_sticky: assert property (@(posedge clk) halt && !rst |=> halt)
    else $error("halt fell without reset");

  no_x0_write: assert property (@(posedge clk) !(commit.we && commit.rd == '0))
    else $error("commit.we is high with rd 0");

  pc_frozen: assert property (@(posedge clk) halt && !rst |=> $stable(pc))
    else $error("pc moved while halted");

endmodule

bind commit_stage rv_core_asserts rv_core_asserts_inst (
  .clk    (clk),
  .rst    (rst),
  .pc     (pc),
  .commit (commit),
  .halt   (halt)
);

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core
  import riscv_pkg::*;
  import core_pkg::*;
();

  localparam word_t RESET_PC    = 32'h0000_0100;  // Low enough for JALR absolute targets
  localparam int    PROG_WORDS  = 64;
  localparam int    NUM_RUNS    = 9;               // One directed, then random
  localparam int    CYCLE_LIMIT = NUM_RUNS * (PROG_WORDS + 8 + 8);
  localparam word_t RNG_SEED    = 32'hde0a_1ab0;

  typedef enum logic [1:0] {IDLE, IN_RESET, RUNNING} tb_mode_e;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  word_t    pc_to_imem;
  word_t    insn_from_imem = INSN_ECALL;
  commit_t  commit;
  logic     halt;

  word_t    prog [PROG_WORDS];
  int       prog_len;
  word_t    rng;
  tb_mode_e mode = IDLE;
  int       cycle_count = 0;
  int       num_checks = 0;

  // Architectural model
  word_t    model_regs [NUM_REGS];
  word_t    model_pc;
  logic     model_halted;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) rv_core_inst (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .commit         (commit),
    .halt           (halt)
  );

  always #10 clk = ~clk;

  function automatic word_t xorshift(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // Outside the program the memory answers with ECALL
  function automatic word_t fetch(input word_t addr);
    word_t off;
    off = addr - RESET_PC;
    if (off < PROG_WORDS * 4 && off[1:0] == 2'b00) begin
      return prog[off[7:2]];
    end
    return INSN_ECALL;
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t x, input word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt) begin
          return $signed(x) >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t x, input word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      3'b111:  return x >= y;
      default: return 1'b0;  // Reserved encodings never branch
    endcase
  endfunction

  // One architectural step at model_pc
  function automatic commit_t ref_step(input word_t insn, output word_t next_pc,
                                       output logic stop);
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       wr;
    commit_t    c;
    f3      = insn[14:12];
    f7      = insn[31:25];
    a       = model_regs[insn[19:15]];
    b       = model_regs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u   = {insn[31:12], 12'h000};
    imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    wr      = 1'b0;
    c.data  = '0;
    next_pc = model_pc + 32'd4;
    stop    = 1'b0;
    case (insn[6:0])
      OP_LUI: begin
        wr     = 1'b1;
        c.data = imm_u;
      end
      OP_AUIPC: begin
        wr     = 1'b1;
        c.data = model_pc + imm_u;
      end
      OP_JAL: begin
        wr      = 1'b1;
        c.data  = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
      end
      OP_JALR: if (f3 == 3'b000) begin
        wr      = 1'b1;
        c.data  = model_pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      OP_BRANCH: if (branch_taken(f3, a, b)) begin
        next_pc = model_pc + imm_b;
      end
      OP_IMM: if (f3 == 3'b001 ? f7 == 7'h00 : (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20)) begin
        wr     = 1'b1;
        c.data = alu_ref(f3, f3 == 3'b101 && insn[30], a, imm_i);
      end
      OP_REG: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
        wr     = 1'b1;
        c.data = alu_ref(f3, insn[30], a, b);
      end
      OP_SYSTEM: stop = (insn == INSN_ECALL);
      default: ;  // Dropped or unknown encodings do nothing
    endcase
    c.we = wr && insn[11:7] != 5'd0;
    c.rd = insn[11:7];
    c.pc = model_pc;
    return c;
  endfunction

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got.we !== exp.we || got.pc !== exp.pc ||
        (exp.we && (got.rd !== exp.rd || got.data !== exp.data))) begin
      $display("error %0t: commit pc=%h we=%b rd=%0d %h, expected pc=%h we=%b rd=%0d %h",
               $time, got.pc, got.we, got.rd, got.data, exp.pc, exp.we, exp.rd, exp.data);
      $display("TEST FAILED");
      $fatal(1, "Commit mismatch");
    end
  endtask

  task automatic check_pc(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error %0t: pc_to_imem is %h, expected %h", $time, got, exp);
      $display("TEST FAILED");
      $fatal(1, "PC mismatch");
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %0t: halt is %b, expected %b", $time, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Halt mismatch");
    end
  endtask

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_directed();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = INSN_ECALL;
    end
    prog_len = 0;
    emit(enc_i(12'hFFB, 5'd0, 3'b000, 5'd1, OP_IMM));    // x1 = -5
    emit(enc_i(12'h007, 5'd0, 3'b000, 5'd2, OP_IMM));    // x2 = 7
    emit(enc_u(20'h80000, 5'd3, OP_LUI));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));        // SUB
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd6));        // SLT
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd7));        // SLTU
    emit(enc_r(7'h20, 5'd2, 5'd3, 3'b101, 5'd8));        // SRA
    emit(enc_i(12'h404, 5'd3, 3'b101, 5'd10, OP_IMM));   // SRAI by 4
    emit(enc_u(20'h12345, 5'd15, OP_AUIPC));
    emit(enc_i(12'h001, 5'd2, 3'b000, 5'd0, OP_IMM));    // Write to x0
    emit(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd16));       // Reads x0
    emit(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd17));       // MUL is illegal here
    emit(enc_b(13'd8, 5'd2, 5'd2, 3'b000));              // BEQ taken
    emit(enc_i(12'h001, 5'd0, 3'b000, 5'd18, OP_IMM));
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b110));              // BLTU not taken
    emit(enc_j(21'd8, 5'd19));
    emit(enc_i(12'h002, 5'd0, 3'b000, 5'd18, OP_IMM));
    emit(enc_i(12'(RESET_PC + 32'd81), 5'd0, 3'b000, 5'd20, OP_JALR));  // Odd target
  endtask

  task automatic load_random();
    word_t       r;
    word_t       s;
    int          span;
    int          fwd;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    word_t       jalr_tgt;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = INSN_ECALL;  // Last word stays ECALL
    end
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      rng   = xorshift(rng);
      r     = rng;
      rng   = xorshift(rng);
      s     = rng;
      span  = PROG_WORDS - 1 - i;
      fwd   = 4 * (1 + int'(s[15:0]) % span);  // Forward, never past the last word
      rd    = {2'b00, r[6:4]};                 // x0..x7 so operands collide often
      rs1   = {2'b00, r[9:7]};
      rs2   = {2'b00, r[12:10]};
      f3    = r[15:13];
      imm12 = s[31:20];
      case (r[3:0])
        4'd0: prog[i] = enc_u(s[31:12], rd, OP_LUI);
        4'd1: prog[i] = enc_u(s[31:12], rd, OP_AUIPC);
        4'd2, 4'd3, 4'd4, 4'd5: begin
          if (f3 == 3'b001) begin
            imm12[11:5] = 7'h00;
          end else if (f3 == 3'b101) begin
            imm12[11:5] = {1'b0, r[16], 5'b00000};
          end
          prog[i] = enc_i(imm12, rs1, f3, rd, OP_IMM);
        end
        4'd9, 4'd10, 4'd11: begin
          if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;  // Fold reserved funct3 onto BLTU/BGEU
          end
          prog[i] = enc_b(13'(fwd), rs2, rs1, f3);
        end
        4'd12: prog[i] = enc_j(21'(fwd), rd);
        4'd13: begin
          jalr_tgt = RESET_PC + word_t'(4 * i + fwd) + {31'b0, s[16]};
          prog[i]  = enc_i(jalr_tgt[11:0], 5'd0, 3'b000, rd, OP_JALR);
        end
        4'd14: prog[i] = {r[31:7], 7'b0001111};  // FENCE
        default: begin
          prog[i] = enc_r(((f3 == 3'b000 || f3 == 3'b101) && r[16]) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd);
        end
      endcase
    end
  endtask

  task automatic run_program(input int run);
    @(posedge clk);
    #1;
    rst  = 1'b1;
    mode = IDLE;
    if (run == 0) begin
      load_directed();
    end else begin
      load_random();
    end
    @(posedge clk);
    #1;
    mode = IN_RESET;
    repeat (7) @(posedge clk);
    #1;
    rst  = 1'b0;
    mode = RUNNING;
    do begin
      @(posedge clk);
      #1;
    end while (!halt);
    repeat (3) @(posedge clk);  // PC must hold while halted
  endtask

  always @(posedge clk) begin
    #1;
    insn_from_imem = fetch(pc_to_imem);
  end

  // Sample mid-cycle, when the fetched word and the commit are settled
  always @(negedge clk) begin
    commit_t exp;
    word_t   npc;
    logic    stop;
    if (mode == IN_RESET) begin
      exp = '{we: 1'b0, rd: '0, data: '0, pc: RESET_PC};
      check_pc(pc_to_imem, RESET_PC);
      check_halt(halt, 1'b0);
      check_commit(commit, exp);
      model_pc     = RESET_PC;
      model_halted = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
    end else if (mode == RUNNING) begin
      check_pc(pc_to_imem, model_pc);
      check_halt(halt, model_halted);
      npc  = model_pc;
      stop = 1'b0;
      if (model_halted) begin
        exp = '{we: 1'b0, rd: '0, data: '0, pc: model_pc};
      end else begin
        exp = ref_step(fetch(model_pc), npc, stop);
      end
      check_commit(commit, exp);
      num_checks++;
      if (exp.we) begin
        model_regs[exp.rd] = exp.data;
      end
      if (!model_halted) begin
        if (stop) begin
          model_halted = 1'b1;
        end else begin
          model_pc = npc;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  initial begin
    rng = RNG_SEED;
    for (int run = 0; run < NUM_RUNS; run++) begin
      run_program(run);
    end
    if (num_checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("No instruction was checked");
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/riscv_pkg.sv
src/core_pkg.sv
src/insn_decoder.sv
src/reg_file.sv
src/alu.sv
src/branch_unit.sv
src/commit_stage.sv
src/rv_core.sv
test/rv_core_asserts.sv
test/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert -f verilog.f --top-module tb_rv_core \
  --Mdir "$BUILD_DIR" -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_rv_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
